//--- line_fill.f
source/axi_pkg.sv
source/line_pkg.sv
source/line_request_stage.sv
source/axi_read_bridge.sv
source/line_assembler.sv
source/line_fill_top.sv
testbench/axi_memory_model.sv
testbench/line_fill_tb.sv

//--- source/axi_pkg.sv
package axi_pkg;

    // ========================================================================
    // bus widths
    // ========================================================================
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int ID_WIDTH   = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ID_WIDTH-1:0]   id_t;

    // ========================================================================
    // encodings
    // ========================================================================
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] AXSIZE_8B  = 3'd3;   // 8 bytes per beat

    // ========================================================================
    // read channel payloads
    // ========================================================================
    typedef struct packed {
        addr_t      addr;
        id_t        id;
        logic [7:0] len;     // beats minus one
        logic [2:0] size;
        logic [1:0] burst;
    } ar_chan_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        id_t   id;
        logic  last;
    } r_chan_t;

endpackage

//--- source/axi_read_bridge.sv
module axi_read_bridge #(
    parameter int LINE_BEATS = 4
) (
    input  logic                clock,
    input  logic                reset,

    // from the request stage
    input  logic                lreq_valid_i,
    input  line_pkg::line_req_t lreq_i,

    // AXI read address channel
    output logic                ar_valid_o,
    input  logic                ar_ready_i,
    output axi_pkg::ar_chan_t   ar_o,

    // AXI read data channel
    input  logic                r_valid_i,
    output logic                r_ready_o,
    input  axi_pkg::r_chan_t    r_i,

    // to the line assembler
    output logic                beat_valid_o,
    output line_pkg::beat_t     beat_o
);

    import axi_pkg::*;
    import line_pkg::*;

    localparam int CNT_WIDTH = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;
    localparam logic [CNT_WIDTH-1:0] LAST_IDX = CNT_WIDTH'(LINE_BEATS - 1);
    localparam logic [7:0] AR_LEN = 8'(LINE_BEATS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t               state_q;
    line_req_t            req_q;
    logic [CNT_WIDTH-1:0] beat_cnt_q;

    logic r_fire;
    logic last_beat;
    logic resp_bad;
    logic id_bad;
    logic last_bad;

    // ========================================================================
    // channel outputs
    // ========================================================================
    assign ar_valid_o = (state_q == ST_ADDR);
    assign r_ready_o  = (state_q == ST_DATA);

    // held stable by req_q while the address phase waits
    assign ar_o = '{
        addr:  req_q.addr,
        id:    req_q.id,
        len:   AR_LEN,
        size:  AXSIZE_8B,
        burst: BURST_INCR
    };

    // ========================================================================
    // beat checks
    // ========================================================================
    assign r_fire    = r_valid_i && r_ready_o;
    assign last_beat = (beat_cnt_q == LAST_IDX);   // the count ends the burst
    assign resp_bad  = (r_i.resp == RESP_SLVERR) || (r_i.resp == RESP_DECERR);
    assign id_bad    = (r_i.id != req_q.id);
    assign last_bad  = (r_i.last != last_beat);    // early or late last

    // ========================================================================
    // control
    // ========================================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            state_q      <= ST_IDLE;
            beat_cnt_q   <= '0;
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= r_fire;
            case (state_q)
                ST_IDLE: begin
                    if (lreq_valid_i) state_q <= ST_ADDR;
                end
                ST_ADDR: begin
                    if (ar_ready_i) state_q <= ST_DATA;
                end
                ST_DATA: begin
                    if (r_fire) begin
                        if (last_beat) begin
                            state_q    <= ST_IDLE;
                            beat_cnt_q <= '0;
                        end else begin
                            beat_cnt_q <= beat_cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ========================================================================
    // payload
    // ========================================================================
    always_ff @(posedge clock) begin
        if (lreq_valid_i && state_q == ST_IDLE) begin
            req_q <= lreq_i;
        end
        if (r_fire) begin
            beat_o.data <= r_i.data;
            beat_o.err  <= resp_bad || id_bad || last_bad;
            beat_o.last <= last_beat;
        end
    end

endmodule

//--- source/line_assembler.sv
module line_assembler #(
    parameter int LINE_BEATS = 4
) (
    input  logic                                clock,
    input  logic                                reset,

    input  logic                                lreq_valid_i,
    input  line_pkg::line_req_t                 lreq_i,

    input  logic                                beat_valid_i,
    input  line_pkg::beat_t                     beat_i,

    output logic                                ack_o,
    output line_pkg::line_info_t                line_info_o,
    output axi_pkg::data_t [LINE_BEATS-1:0]     line_data_o
);

    import axi_pkg::*;

    localparam int IDX_WIDTH = (LINE_BEATS > 1) ? $clog2(LINE_BEATS) : 1;

    addr_t                  addr_q;
    data_t [LINE_BEATS-1:0] buf_q;      // beats of the line in flight
    logic [IDX_WIDTH-1:0]   idx_q;
    logic                   err_q;
    logic                   line_done;

    assign line_done = beat_valid_i && beat_i.last;

    // ========================================================================
    // control
    // ========================================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            ack_o <= 1'b0;
            idx_q <= '0;
            err_q <= 1'b0;
        end else begin
            ack_o <= line_done;
            if (lreq_valid_i) begin
                idx_q <= '0;
                err_q <= 1'b0;
            end else if (beat_valid_i) begin
                idx_q <= idx_q + 1'b1;
                err_q <= err_q | beat_i.err;
            end
        end
    end

    // ========================================================================
    // line buffer and outputs
    // ========================================================================

    // outputs load only on the last beat, so they hold until the next ack
    always_ff @(posedge clock) begin
        if (lreq_valid_i) begin
            addr_q <= lreq_i.addr;
        end
        if (beat_valid_i) begin
            buf_q[idx_q] <= beat_i.data;
        end
        if (line_done) begin
            line_info_o.addr <= addr_q;
            line_info_o.err  <= err_q | beat_i.err;
            for (int i = 0; i < LINE_BEATS; i++) begin
                if (IDX_WIDTH'(i) == idx_q) begin
                    line_data_o[i] <= beat_i.data;   // last beat bypasses buf_q
                end else begin
                    line_data_o[i] <= buf_q[i];
                end
            end
        end
    end

endmodule

//--- source/line_fill_top.sv
module line_fill_top #(
    parameter int LINE_BEATS = 4
) (
    input  logic                                clock,
    input  logic                                reset,

    // requester side
    input  logic                                req_i,
    input  axi_pkg::addr_t                      addr_i,
    output logic                                ack_o,
    output line_pkg::line_info_t                line_info_o,
    output axi_pkg::data_t [LINE_BEATS-1:0]     line_data_o,

    // AXI read master
    output logic                                ar_valid_o,
    input  logic                                ar_ready_i,
    output axi_pkg::ar_chan_t                   ar_o,
    input  logic                                r_valid_i,
    output logic                                r_ready_o,
    input  axi_pkg::r_chan_t                    r_i
);

    import line_pkg::*;

    logic      lreq_valid;
    line_req_t lreq;
    logic      beat_valid;
    beat_t     beat;

    // ========================================================================
    // request -> read bridge -> assembler
    // ========================================================================
    line_request_stage #(
        .LINE_BEATS   (LINE_BEATS)
    ) i_line_request_stage (
        .clock        (clock),
        .reset        (reset),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .ack_i        (ack_o),          // frees the stage for the next line
        .lreq_valid_o (lreq_valid),
        .lreq_o       (lreq)
    );

    axi_read_bridge #(
        .LINE_BEATS   (LINE_BEATS)
    ) i_axi_read_bridge (
        .clock        (clock),
        .reset        (reset),
        .lreq_valid_i (lreq_valid),
        .lreq_i       (lreq),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .ar_o         (ar_o),
        .r_valid_i    (r_valid_i),
        .r_ready_o    (r_ready_o),
        .r_i          (r_i),
        .beat_valid_o (beat_valid),
        .beat_o       (beat)
    );

    line_assembler #(
        .LINE_BEATS   (LINE_BEATS)
    ) i_line_assembler (
        .clock        (clock),
        .reset        (reset),
        .lreq_valid_i (lreq_valid),
        .lreq_i       (lreq),
        .beat_valid_i (beat_valid),
        .beat_i       (beat),
        .ack_o        (ack_o),
        .line_info_o  (line_info_o),
        .line_data_o  (line_data_o)
    );

endmodule

//--- source/line_pkg.sv
package line_pkg;

    import axi_pkg::*;

    // bytes carried by one beat
    localparam int BEAT_BYTES = DATA_WIDTH / 8;

    // request stage to read bridge and assembler
    typedef struct packed {
        addr_t addr;    // line aligned
        id_t   id;      // tag stamped by the request stage
    } line_req_t;

    // read bridge to assembler for every accepted R beat
    typedef struct packed {
        data_t data;
        logic  err;     // bad response, id or last on this beat
        logic  last;
    } beat_t;

    // returned alongside the line data
    typedef struct packed {
        addr_t addr;
        logic  err;     // any beat of the line failed
    } line_info_t;

endpackage

//--- source/line_request_stage.sv
module line_request_stage #(
    parameter int LINE_BEATS = 4
) (
    input  logic                clock,
    input  logic                reset,

    input  logic                req_i,
    input  axi_pkg::addr_t      addr_i,
    input  logic                ack_i,

    output logic                lreq_valid_o,
    output line_pkg::line_req_t lreq_o
);

    import axi_pkg::*;
    import line_pkg::*;

    localparam int LINE_BYTES = LINE_BEATS * BEAT_BYTES;

    logic  busy_q;      // a line is in flight
    id_t   tag_q;
    logic  accept;
    addr_t line_addr;

    // ========================================================================
    // accept and align
    // ========================================================================

    // a held req_i is not taken again until the ack has cleared busy
    assign accept    = req_i && !busy_q;
    assign line_addr = addr_i & ~addr_t'(LINE_BYTES - 1);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q       <= 1'b0;
            lreq_valid_o <= 1'b0;
            tag_q        <= '0;
        end else begin
            lreq_valid_o <= 1'b0;
            if (ack_i) begin
                busy_q <= 1'b0;     // req_i ignored in the ack cycle
            end else if (accept) begin
                busy_q       <= 1'b1;
                lreq_valid_o <= 1'b1;
                tag_q        <= tag_q + 1'b1;   // wraps
            end
        end
    end

    // ========================================================================
    // request payload
    // ========================================================================
    always_ff @(posedge clock) begin
        if (accept && !ack_i) begin
            lreq_o.addr <= line_addr;
            lreq_o.id   <= tag_q;
        end
    end

endmodule

//--- testbench/axi_memory_model.sv
module axi_memory_model #(
    parameter integer SEED = 32'hd3a3
) (
    input  logic              clock,
    input  logic              reset,

    input  logic              ar_valid_i,
    output logic              ar_ready_o,
    input  axi_pkg::ar_chan_t ar_i,

    output logic              r_valid_o,
    input  logic              r_ready_i,
    output axi_pkg::r_chan_t  r_o
);

    import axi_pkg::*;

    integer     seed;
    logic       sending;        // a burst is being returned
    addr_t      beat_addr;
    logic [8:0] beats_left;
    id_t        burst_id;

    // low half is the address, high half the address XOR 5a5a5a5a
    function automatic data_t word_at(input addr_t a);
        return {a ^ 32'h5a5a_5a5a, a};
    endfunction

    initial begin
        seed       = SEED;
        sending    = 1'b0;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
    end

    always @(posedge clock) begin
        if (reset) begin
            sending = 1'b0;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
        end else begin
            // ========================================================================
            // address channel
            // ========================================================================
            if (ar_valid_i && ar_ready_o) begin
                sending    = 1'b1;
                beat_addr  = ar_i.addr;
                beats_left = ar_i.len + 9'd1;
                burst_id   = ar_i.id;
                ar_ready_o <= 1'b0;
            end else begin
                ar_ready_o <= !sending && (($random(seed) & 3) != 0);   // random stalls
            end

            // ========================================================================
            // data channel
            // ========================================================================
            if (r_valid_o && r_ready_i) begin
                beat_addr  = beat_addr + 8;
                beats_left = beats_left - 9'd1;
                sending    = (beats_left != 0);
            end
            if (!r_valid_o || r_ready_i) begin      // a beat on offer is held until taken
                if (sending && (($random(seed) & 3) != 0)) begin
                    r_valid_o <= 1'b1;
                    r_o.data  <= word_at(beat_addr);
                    r_o.resp  <= beat_addr[12] ? RESP_SLVERR : RESP_OKAY;
                    r_o.id    <= burst_id;
                    r_o.last  <= (beats_left == 9'd1);
                end else begin
                    r_valid_o <= 1'b0;              // gap
                end
            end
        end
    end

endmodule

//--- testbench/line_fill_tb.sv
module line_fill_tb;

    import axi_pkg::*;
    import line_pkg::*;

    localparam int    LINE_BEATS = 4;
    localparam addr_t LINE_MASK  = 32'hffff_ffe0;  // 32 byte line, low 5 bits cleared
    localparam int    TIMEOUT    = 200;

    typedef struct packed {
        line_info_t             info;
        data_t [LINE_BEATS-1:0] data;
    } expected_t;

    logic clock;
    logic reset;
    logic req;
    addr_t addr;
    logic ack;
    line_info_t line_info;
    data_t [LINE_BEATS-1:0] line_data;
    logic ar_valid;
    logic ar_ready;
    ar_chan_t ar;
    logic r_valid;
    logic r_ready;
    r_chan_t r;

    integer seed = 32'hd3a3;
    addr_t pending[$];      // requests still waiting for their ack
    int value_errors;
    int protocol_errors;
    int issued;
    int acks;
    int ar_count;
    logic timed_out;
    expected_t exp_line;
    ar_chan_t exp_ar;

    line_fill_top #(
        .LINE_BEATS (LINE_BEATS)
    ) i_line_fill_top (
        .clock (clock), .reset (reset),
        .req_i (req), .addr_i (addr), .ack_o (ack),
        .line_info_o (line_info), .line_data_o (line_data),
        .ar_valid_o (ar_valid), .ar_ready_i (ar_ready), .ar_o (ar),
        .r_valid_i (r_valid), .r_ready_o (r_ready), .r_i (r)
    );

    axi_memory_model i_axi_memory_model (
        .clock (clock), .reset (reset),
        .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_i (ar),
        .r_valid_o (r_valid), .r_ready_i (r_ready), .r_o (r)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // ========================================================================
    // reference model and compare tasks
    // ========================================================================
    function automatic expected_t expected_line(input addr_t req_addr);
        expected_t result;
        addr_t     beat_addr;
        result.info.addr = req_addr & LINE_MASK;
        result.info.err  = 1'b0;
        for (int i = 0; i < LINE_BEATS; i++) begin
            beat_addr       = result.info.addr + addr_t'(8 * i);
            result.data[i]  = {beat_addr ^ 32'h5a5a_5a5a, beat_addr};
            result.info.err = result.info.err | beat_addr[12];   // SLVERR window
        end
        return result;
    endfunction

    task automatic check_info(input line_info_t got, input line_info_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: line info addr %08h err %b, expected addr %08h err %b",
                     $time, got.addr, got.err, exp.addr, exp.err);
            value_errors++;
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input int beat);
        if (got !== exp) begin
            $display("** Error at %0t: beat %0d data %016h, expected %016h",
                     $time, beat, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_ar(input ar_chan_t got, input ar_chan_t exp);
        if (got !== exp) begin
            $write("** Error at %0t: AR addr %08h id %0d len %0d size %0d burst %0d",
                   $time, got.addr, got.id, got.len, got.size, got.burst);
            $display(", expected %08h %0d %0d %0d %0d",
                     exp.addr, exp.id, exp.len, exp.size, exp.burst);
            value_errors++;
        end
    endtask

    // ========================================================================
    // requester
    // ========================================================================
    task automatic request_line(input addr_t line_addr);
        int   cycles;
        logic seen;
        if (!timed_out) begin
            repeat ($random(seed) & 3) @(posedge clock);
            pending.push_back(line_addr);
            issued++;
            @(posedge clock);
            req  <= 1'b1;
            addr <= line_addr;
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < TIMEOUT) begin
                @(negedge clock);
                seen = ack;
                cycles++;
            end
            @(posedge clock);
            req <= 1'b0;        // held through the ack cycle, must not start a second line
            if (!seen) begin
                $display("no acknowledge for line request %08h", line_addr);
                protocol_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // ========================================================================
    // monitors
    // ========================================================================
    always @(negedge clock) begin
        if (reset && (ack !== 1'b0 || ar_valid !== 1'b0 || r_ready !== 1'b0)) begin
            $display("ack, AR valid or R ready raised during reset at time %0t", $time);
            protocol_errors++;
        end else if (!reset && ar_valid === 1'b1 && r_ready === 1'b1) begin
            $display("R ready raised before the AR burst was accepted at time %0t", $time);
            protocol_errors++;
        end
    end

    // compare process checks one line per ack
    always @(negedge clock) begin
        if (!reset && ack === 1'b1) begin
            if (pending.size() == 0) begin
                $display("acknowledge without a pending request at time %0t", $time);
                protocol_errors++;
            end else begin
                exp_line = expected_line(pending.pop_front());
                check_info(line_info, exp_line.info);
                for (int i = 0; i < LINE_BEATS; i++) begin
                    check_data(line_data[i], exp_line.data[i], i);
                end
                acks++;
            end
        end
    end

    always @(negedge clock) begin
        if (!reset && ar_valid && ar_ready) begin
            if (pending.size() == 0) begin
                $display("AR burst without a pending request at time %0t", $time);
                protocol_errors++;
            end else begin
                exp_ar.addr  = pending[0] & LINE_MASK;
                exp_ar.id    = id_t'(ar_count);     // tag counter starts at zero after reset
                exp_ar.len   = 8'(LINE_BEATS - 1);
                exp_ar.size  = 3'd3;
                exp_ar.burst = BURST_INCR;
                check_ar(ar, exp_ar);
            end
            ar_count++;
        end
    end

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        addr_t rand_addr;
        reset = 1'b1;
        req = 1'b0;
        addr = '0;
        value_errors = 0;
        protocol_errors = 0;
        issued = 0;
        acks = 0;
        ar_count = 0;
        timed_out = 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        request_line(32'h0000_0100);    // aligned
        request_line(32'h0000_0020);
        request_line(32'h8000_0fe0);
        request_line(32'h0000_0237);    // unaligned
        request_line(32'h7fff_0abf);
        request_line(32'h0000_1000);    // error window
        request_line(32'h0004_1fe5);
        for (int n = 0; n < 24; n++) begin
            rand_addr = $random(seed);
            request_line(rand_addr);
        end

        repeat (20) @(posedge clock);   // a stray second ack would show here
        if (!timed_out && (pending.size() != 0 || acks != issued)) begin
            $display("%0d lines requested but %0d acknowledged", issued, acks);
            protocol_errors++;
        end
        $display("errors: %0d value, %0d protocol, lines acknowledged %0d of %0d",
                 value_errors, protocol_errors, acks, issued);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
